// ==== src.f ====
+incdir+.
wb_pkg.sv
wb_if.sv
wb_interconnect.sv
wb_scratch_regs.sv
wb_interval_timer.sv
wb_subsystem_top.sv
tb_wb_subsystem.sv

// ==== tb_wb_subsystem.sv ====
// testbench driving the wishbone subsystem master port through scratch, unmapped and timer traffic
`timescale 1ns/10ps
`include "wb_macros.svh"

module tb_wb_subsystem;

    localparam int ACK_TIMEOUT = 20;

    logic         clk = 1'b0;
    logic         arst_n_i;
    logic         wb_cyc_i;
    logic         wb_stb_i;
    logic         wb_we_i;
    wb_pkg::adr_t wb_adr_i;
    wb_pkg::dat_t wb_dat_i;
    wb_pkg::dat_t wb_dat_o;
    logic         wb_ack_o;
    logic         wb_int_o;

    // expected read data, only checked while chk_dat is set
    wb_pkg::dat_t exp_dat;
    bit           chk_dat;
    wb_pkg::dat_t ref_mem [`WB_SCRATCH_DEPTH];
    int           errors;
    int           err_mark;
    int           tests_ok;
    int           tests_bad;
    int unsigned  cycle_cnt;

    wb_subsystem_top dut (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .wb_int_o (wb_int_o)
    );

    // 4 ns clock
    always #2 clk = ~clk;

    // free cycle count for polling budgets
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // new request answered exactly one cycle later
    a_ack_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        $rose(wb_cyc_i && wb_stb_i) |-> !wb_ack_o ##1 wb_ack_o)
        else begin
            errors++;
            $display("ack did not follow the request at address %h by one cycle",
                     $sampled(wb_adr_i));
        end

    // ack never stretches
    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o)
        else begin
            errors++;
            $display("ack stayed high for more than one cycle");
        end

    // read data on ack against the reference
    a_read_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        (wb_ack_o && !wb_we_i && chk_dat) |-> (wb_dat_o == exp_dat))
        else begin
            errors++;
            $display("** Error: wb_dat_o expected %h got %h", $sampled(exp_dat),
                     $sampled(wb_dat_o));
        end

    // one handshake, held until ack or timeout, then one idle cycle
    task automatic run_cycle(input logic we, input wb_pkg::adr_t adr,
                             input wb_pkg::dat_t wdat, output wb_pkg::dat_t rdat);
        int n;
        bit got;
        n    = 0;
        got  = 1'b0;
        rdat = '0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        while (!got && n < ACK_TIMEOUT) begin
            @(posedge clk);
            n++;
            if (wb_ack_o) begin
                got  = 1'b1;
                rdat = wb_dat_o;
            end
        end
        if (!got) begin
            errors++;
            $display("no ack within %0d cycles for access at address %h", ACK_TIMEOUT, adr);
        end
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(posedge clk);
    endtask

    task automatic bus_write(input wb_pkg::adr_t adr, input wb_pkg::dat_t wdat);
        wb_pkg::dat_t unused;
        run_cycle(1'b1, adr, wdat, unused);
    endtask

    // check picks whether the data assertion compares against exp
    task automatic bus_read(input wb_pkg::adr_t adr, input bit check,
                            input wb_pkg::dat_t exp, output wb_pkg::dat_t rdat);
        exp_dat = exp;
        chk_dat = check;
        run_cycle(1'b0, adr, '0, rdat);
        chk_dat = 1'b0;
    endtask

    // scratch word address with random alias bits 23:6
    function automatic wb_pkg::adr_t scratch_adr(input int idx);
        logic [17:0] alias_bits;
        alias_bits = 18'($urandom);
        return {`WB_SEL_SCRATCH, alias_bits, 4'(idx), 2'b00};
    endfunction

    function automatic wb_pkg::adr_t timer_adr(input wb_pkg::tmr_reg_e r);
        return {`WB_SEL_TIMER, 20'h0, 4'(r)};
    endfunction

    task automatic close_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        int           idx;
        int unsigned  cmp;
        int unsigned  t0;
        int unsigned  n;
        logic [7:0]   sel;
        wb_pkg::dat_t data;
        wb_pkg::dat_t rdat;
        wb_pkg::dat_t cnt_a;
        wb_pkg::adr_t adr;
        void'($urandom(32'hdff1));
        arst_n_i  = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        exp_dat   = '0;
        chk_dat   = 1'b0;
        errors    = 0;
        err_mark  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        cycle_cnt = 0;
        repeat (10) @(posedge clk);
        arst_n_i <= 1'b1;
        @(posedge clk);

        // all words clear after reset
        for (int i = 0; i < `WB_SCRATCH_DEPTH; i++) begin
            ref_mem[i] = '0;
            bus_read(scratch_adr(i), 1'b1, '0, rdat);
        end
        assert (!wb_int_o) else begin
            errors++;
            $display("** Error: wb_int_o expected 0 got 1");
        end
        close_test("reset values");

        // random writes through aliased addresses
        for (int i = 0; i < 40; i++) begin
            idx  = $urandom_range(`WB_SCRATCH_DEPTH - 1, 0);
            data = $urandom;
            ref_mem[idx] = data;
            bus_write(scratch_adr(idx), data);
        end
        for (int i = 0; i < `WB_SCRATCH_DEPTH; i++) begin
            bus_read(scratch_adr(i), 1'b1, ref_mem[i], rdat);
        end
        close_test("scratch write and read");

        // unmapped select bytes answer with zero and write nothing
        for (int i = 0; i < 8; i++) begin
            sel  = 8'($urandom_range(255, 2));
            idx  = $urandom_range(`WB_SCRATCH_DEPTH - 1, 0);
            adr  = scratch_adr(idx);
            adr[`WB_SEL_HI:`WB_SEL_LO] = sel;
            bus_write(adr, $urandom);
            bus_read(adr, 1'b1, '0, rdat);
            bus_read(scratch_adr(idx), 1'b1, ref_mem[idx], rdat);
        end
        close_test("unmapped access");

        // timer match with interrupt masked
        cmp = $urandom_range(15, 4);
        bus_write(timer_adr(wb_pkg::TMR_CMP), cmp);
        bus_read(timer_adr(wb_pkg::TMR_CMP), 1'b1, cmp, rdat);
        bus_write(timer_adr(wb_pkg::TMR_CTRL), 32'h1);
        t0   = cycle_cnt;
        rdat = '0;
        while (!rdat[0] && (cycle_cnt - t0) <= cmp + 4) begin
            bus_read(timer_adr(wb_pkg::TMR_STAT), 1'b0, '0, rdat);
            assert (!wb_int_o) else begin
                errors++;
                $display("** Error: wb_int_o expected 0 got 1");
            end
        end
        assert (rdat[0]) else begin
            errors++;
            $display("timer status not set within %0d cycles", cmp + 4);
        end
        bus_read(timer_adr(wb_pkg::TMR_CNT), 1'b0, '0, rdat);
        assert (rdat <= cmp) else begin
            errors++;
            $display("** Error: wb_dat_o count expected at most %h got %h", cmp, rdat);
        end
        close_test("timer status");

        // stop, clear status, then run with interrupt enabled
        bus_write(timer_adr(wb_pkg::TMR_CTRL), 32'h0);
        bus_write(timer_adr(wb_pkg::TMR_STAT), 32'h1);
        bus_write(timer_adr(wb_pkg::TMR_CTRL), 32'h3);
        n = 0;
        while (!wb_int_o && n < cmp + 4) begin
            @(posedge clk);
            n++;
        end
        assert (wb_int_o) else begin
            errors++;
            $display("timer interrupt did not rise within %0d cycles", cmp + 4);
        end
        // counter stopped, irq held by status
        bus_write(timer_adr(wb_pkg::TMR_CTRL), 32'h2);
        assert (wb_int_o) else begin
            errors++;
            $display("** Error: wb_int_o expected 1 got 0");
        end
        bus_write(timer_adr(wb_pkg::TMR_STAT), 32'h1);
        assert (!wb_int_o) else begin
            errors++;
            $display("** Error: wb_int_o expected 0 got 1");
        end
        bus_read(timer_adr(wb_pkg::TMR_CNT), 1'b0, '0, cnt_a);
        bus_read(timer_adr(wb_pkg::TMR_CNT), 1'b1, cnt_a, rdat);
        assert (!wb_int_o) else begin
            errors++;
            $display("** Error: wb_int_o expected 0 got 1");
        end
        close_test("timer interrupt");

        $display("%0d tests ok, %0d tests with errors, %0d errors in all",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== wb_subsystem_top.sv ====
// wishbone subsystem top level with scratch registers and interval timer behind one port
`timescale 1ns/10ps
`include "wb_macros.svh"

module wb_subsystem_top (
    input  logic         clk,
    input  logic         arst_n_i,
    // master port
    input  logic         wb_cyc_i,
    input  logic         wb_stb_i,
    input  logic         wb_we_i,
    input  wb_pkg::adr_t wb_adr_i,
    input  wb_pkg::dat_t wb_dat_i,
    output wb_pkg::dat_t wb_dat_o,
    output logic         wb_ack_o,
    // timer interrupt out
    output logic         wb_int_o
);

    // timer interrupt, kept outside the bus bundle
    logic tmr_irq;

    // one link per slave
    wb_if s0_bus ();
    wb_if s1_bus ();

    // address decode and response merge
    wb_interconnect u_interconnect (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .m_cyc_i   (wb_cyc_i),
        .m_stb_i   (wb_stb_i),
        .m_we_i    (wb_we_i),
        .m_adr_i   (wb_adr_i),
        .m_dat_i   (wb_dat_i),
        .m_dat_o   (wb_dat_o),
        .m_ack_o   (wb_ack_o),
        .m_int_o   (wb_int_o),
        .s0        (s0_bus.master),
        .s1        (s1_bus.master),
        .tmr_irq_i (tmr_irq)
    );

    // select 00
    wb_scratch_regs u_scratch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (s0_bus.slave)
    );

    // select 01
    wb_interval_timer u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .bus      (s1_bus.slave),
        .irq_o    (tmr_irq)
    );

endmodule

// ==== wb_interval_timer.sv ====
// wishbone slave interval timer with compare match status and interrupt
`timescale 1ns/10ps
`include "wb_macros.svh"

module wb_interval_timer (
    input  logic clk,
    input  logic arst_n_i,
    wb_if.slave  bus,
    output logic irq_o
);

    wb_pkg::tmr_reg_e reg_sel;
    wb_pkg::dat_t     cmp_q;
    wb_pkg::dat_t     cnt_q;
    wb_pkg::dat_t     rdata_q;
    wb_pkg::dat_t     rdata_d;
    logic [1:0]       ctrl_q;
    logic [1:0]       ctrl_d;
    logic             stat_q;
    logic             stat_d;
    logic             irq_q;
    logic             req;
    logic             accept;
    logic             wr;
    logic             ack_q;
    logic             done_q;
    logic             hit;

    // register decode on the low offset bits
    assign reg_sel = wb_pkg::tmr_reg_e'(bus.adr[3:0]);

    assign req    = bus.cyc & bus.stb;
    assign accept = req & ~ack_q & ~done_q;
    assign wr     = accept & bus.we;

    // same one-shot ack as the scratch slave
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= accept;
            done_q <= req & (done_q | ack_q);
        end
    end

    // bit 0 run, bit 1 irq enable
    assign ctrl_d = (wr && reg_sel == wb_pkg::TMR_CTRL) ? bus.dat_w[1:0] : ctrl_q;

    // compare match while running
    assign hit = ctrl_q[0] & (cnt_q == cmp_q);

    // write one clears, a match in the same cycle wins
    assign stat_d = (stat_q & ~(wr && reg_sel == wb_pkg::TMR_STAT && bus.dat_w[0])) | hit;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
            cmp_q  <= '0;
            cnt_q  <= '0;
            stat_q <= 1'b0;
            irq_q  <= 1'b0;
        end else begin
            ctrl_q <= ctrl_d;
            stat_q <= stat_d;
            // irq follows the next status and enable together
            irq_q  <= stat_d & ctrl_d[1];
            if (wr && reg_sel == wb_pkg::TMR_CMP) begin
                cmp_q <= bus.dat_w;
            end
            // free-running, wraps on match, frozen when stopped
            if (hit) begin
                cnt_q <= '0;
            end else if (ctrl_q[0]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // readback mux
    always_comb begin
        case (reg_sel)
            wb_pkg::TMR_CTRL: rdata_d = {{(`WB_DAT_W-2){1'b0}}, ctrl_q};
            wb_pkg::TMR_CMP:  rdata_d = cmp_q;
            wb_pkg::TMR_CNT:  rdata_d = cnt_q;
            wb_pkg::TMR_STAT: rdata_d = {{(`WB_DAT_W-1){1'b0}}, stat_q};
            default:          rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= rdata_d;
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;
    assign irq_o     = irq_q;

    // clearing the enable takes the interrupt down on the same edge
    a_irq_needs_ie: assert property (@(posedge clk) disable iff (!arst_n_i)
        irq_o |-> ctrl_q[1])
        else $error("timer irq high with interrupt enable clear");

endmodule

// ==== wb_scratch_regs.sv ====
// wishbone slave holding a small read/write scratch register file
`timescale 1ns/10ps
`include "wb_macros.svh"

module wb_scratch_regs (
    input  logic clk,
    input  logic arst_n_i,
    wb_if.slave  bus
);

    localparam int IDX_W = $clog2(`WB_SCRATCH_DEPTH);

    wb_pkg::dat_t           mem [`WB_SCRATCH_DEPTH];
    wb_pkg::dat_t           rdata_q;
    logic [IDX_W-1:0]       idx;
    logic                   req;
    logic                   accept;
    logic                   ack_q;
    logic                   done_q;

    // word index from local address, byte bits ignored
    assign idx = bus.adr[IDX_W+1:2];

    assign req = bus.cyc & bus.stb;

    // first edge of a new request
    // done_q covers a master that keeps stb up past ack
    assign accept = req & ~ack_q & ~done_q;

    // handshake state
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= accept;
            done_q <= req & (done_q | ack_q);
        end
    end

    // register file, cleared on reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `WB_SCRATCH_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && bus.we) begin
            mem[idx] <= bus.dat_w;
        end
    end

    // read data lines up with ack
    // write cycles return the old word, master ignores it
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx];
        end
    end

    assign bus.dat_r = rdata_q;
    assign bus.ack   = ack_q;

    // registered ack must still find the request in place
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus.ack |-> (bus.cyc && bus.stb))
        else $error("scratch ack outside of a bus cycle");

endmodule

// ==== wb_interconnect.sv ====
// wishbone interconnect decoding the select byte to two slaves and merging responses
`timescale 1ns/10ps
`include "wb_macros.svh"

module wb_interconnect (
    input  logic         clk,
    input  logic         arst_n_i,
    // single bus master
    input  logic         m_cyc_i,
    input  logic         m_stb_i,
    input  logic         m_we_i,
    input  wb_pkg::adr_t m_adr_i,
    input  wb_pkg::dat_t m_dat_i,
    output wb_pkg::dat_t m_dat_o,
    output logic         m_ack_o,
    output logic         m_int_o,
    // slave links
    wb_if.master         s0,
    wb_if.master         s1,
    input  logic         tmr_irq_i
);

    wb_pkg::sel_t slave_sel;
    wb_pkg::adr_t local_adr;
    logic         hit_s0;
    logic         hit_s1;
    logic         um_req;
    logic         um_ack_q;
    logic         um_done_q;

    // upper byte picks the slave
    assign slave_sel = m_adr_i[`WB_SEL_HI:`WB_SEL_LO];
    assign hit_s0    = (slave_sel == `WB_SEL_SCRATCH);
    assign hit_s1    = (slave_sel == `WB_SEL_TIMER);

    // slaves only see their local offset
    assign local_adr = {{(`WB_ADR_W-`WB_SEL_LO){1'b0}}, m_adr_i[`WB_SEL_LO-1:0]};

    // slave 0 request qualified by select
    assign s0.cyc   = m_cyc_i & hit_s0;
    assign s0.stb   = m_stb_i & hit_s0;
    assign s0.we    = m_we_i & hit_s0;
    assign s0.adr   = local_adr;
    assign s0.dat_w = m_dat_i;

    // slave 1 request qualified by select
    assign s1.cyc   = m_cyc_i & hit_s1;
    assign s1.stb   = m_stb_i & hit_s1;
    assign s1.we    = m_we_i & hit_s1;
    assign s1.adr   = local_adr;
    assign s1.dat_w = m_dat_i;

    // nobody decodes this address
    assign um_req = m_cyc_i & m_stb_i & ~hit_s0 & ~hit_s1;

    // local responder for unmapped space
    // one ack per request and none again until stb drops
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            um_ack_q  <= 1'b0;
            um_done_q <= 1'b0;
        end else begin
            um_ack_q  <= um_req & ~um_ack_q & ~um_done_q;
            um_done_q <= um_req & (um_done_q | um_ack_q);
        end
    end

    // response mux on the address held through ack
    always_comb begin
        case (slave_sel)
            `WB_SEL_SCRATCH: begin
                m_dat_o = s0.dat_r;
                m_ack_o = s0.ack;
            end
            `WB_SEL_TIMER: begin
                m_dat_o = s1.dat_r;
                m_ack_o = s1.ack;
            end
            default: begin
                // unmapped reads return zero
                m_dat_o = '0;
                m_ack_o = um_ack_q;
            end
        endcase
    end

    // only the timer can interrupt
    assign m_int_o = tmr_irq_i;

    // a slave that never saw a strobe has nothing to answer
    a_s0_ack_sel: assert property (@(posedge clk) disable iff (!arst_n_i)
        s0.ack |-> hit_s0)
        else $error("slave 0 answered with select %h", slave_sel);

    a_s1_ack_sel: assert property (@(posedge clk) disable iff (!arst_n_i)
        s1.ack |-> hit_s1)
        else $error("slave 1 answered with select %h", slave_sel);

    // merged ack stays a single pulse whichever source answered
    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        m_ack_o |=> !m_ack_o)
        else $error("master ack high for two cycles");

endmodule

// ==== wb_if.sv ====
// wishbone classic bus bundle between the interconnect and one slave
`timescale 1ns/10ps
`include "wb_macros.svh"

interface wb_if;

    // request side, owned by the master
    logic         cyc;
    logic         stb;
    logic         we;
    wb_pkg::adr_t adr;
    wb_pkg::dat_t dat_w;

    // response side, owned by the slave
    wb_pkg::dat_t dat_r;
    logic         ack;

    // interconnect end of the link
    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        input  dat_r,
        input  ack
    );

    // slave end of the link
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        output dat_r,
        output ack
    );

endinterface

// ==== wb_pkg.sv ====
// wishbone subsystem package with bus vector types and the timer register map
`include "wb_macros.svh"

package wb_pkg;

    // full bus address, select byte included
    typedef logic [`WB_ADR_W-1:0] adr_t;

    // one bus data word
    typedef logic [`WB_DAT_W-1:0] dat_t;

    // upper address byte that picks the slave
    typedef logic [`WB_SEL_HI-`WB_SEL_LO:0] sel_t;

    // timer registers by their byte offset
    // unaligned offsets fall outside the enum and decode as unmapped
    typedef enum logic [3:0] {
        TMR_CTRL = `WB_TMR_CTRL,
        TMR_CMP  = `WB_TMR_CMP,
        TMR_CNT  = `WB_TMR_CNT,
        TMR_STAT = `WB_TMR_STAT
    } tmr_reg_e;

endpackage

// ==== wb_macros.svh ====
// wishbone subsystem bus widths, slave select codes and register map constants
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// bus widths
`define WB_ADR_W 32
`define WB_DAT_W 32

// slave select byte position in the master address
`define WB_SEL_HI 31
`define WB_SEL_LO 24

// select codes, one per slave
`define WB_SEL_SCRATCH 8'h00
`define WB_SEL_TIMER   8'h01

// scratch words, addressed by local bits 5:2
`define WB_SCRATCH_DEPTH 16

// timer register byte offsets
`define WB_TMR_CTRL 4'h0
`define WB_TMR_CMP  4'h4
`define WB_TMR_CNT  4'h8
`define WB_TMR_STAT 4'hC

`endif
